//--- verilog.f
+incdir+.
csr_pkg.sv
csr_access_decode.sv
csr_trap_state.sv
csr_machine_regs.sv
csr_read_mux.sv
csr_file.sv
csr_file_assertions.sv
tb_csr_file.sv

//--- Makefile
# Verilator build and run of the CSR file testbench

obj_dir/Vtb_csr_file: verilog.f csr_settings.svh csr_pkg.sv csr_access_decode.sv \
    csr_trap_state.sv csr_machine_regs.sv csr_read_mux.sv csr_file.sv \
    csr_file_assertions.sv tb_csr_file.sv
	verilator --binary --assert --top-module tb_csr_file -f verilog.f

run: obj_dir/Vtb_csr_file
	@out="$$(./obj_dir/Vtb_csr_file 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- tb_csr_file.sv
// Table-driven testbench for the machine-mode CSR file.
// Each table row drives one access, trap or MRET, then reads the same
// address back a cycle later and compares it with the expected word.

`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_file import csr_pkg::*; ();

    typedef enum logic [2:0] {
        ACT_WRITE, ACT_SET, ACT_CLEAR, ACT_READ, ACT_TRAP_CPU, ACT_TRAP_INT, ACT_MRET
    } action_e;

    typedef struct {
        string                   name;
        action_e                 act;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_XLEN-1:0]    wdata;
        logic [`CSR_XLEN-1:0]    exp_rdata;
        logic                    exp_mie;
        logic [2:0]              mip;       // meip, mtip, msip
        logic [`CSR_CAUSE_W-1:0] cause;
        logic [`CSR_XLEN-1:0]    pc;
        logic [`CSR_XLEN-1:0]    tval;
    } row_t;

    logic g_clk, g_resetn, csr_en, csr_wr, csr_wr_set, csr_wr_clr, exec_mret;
    logic mip_meip, mip_mtip, mip_msip, trap_cpu, trap_int;
    logic [`CSR_ADDR_W-1:0]  csr_addr;
    logic [`CSR_XLEN-1:0]    csr_wdata, trap_mtval, trap_pc;
    logic [`CSR_CAUSE_W-1:0] trap_cause;
    logic [`CSR_XLEN-1:0]    csr_rdata, csr_mepc, csr_mtvec;
    logic                    mstatus_mie, mie_meie, mie_mtie, mie_msie;

    row_t                 rows[$];
    int                   cycle_count = 0;
    int                   timeout_limit = 20;
    logic [`CSR_XLEN-1:0] r0, r1, r2;

    csr_file csr_file_i (.*);

    always #10 g_clk = ~g_clk;

    // Run limit, stops a stuck simulation
    always @(posedge g_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: table not finished after %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1, "run aborted on timeout");
        end
    end

    // --------------------------------------------------
    // Table and compare helpers
    // --------------------------------------------------
    function automatic void add_row(string name, action_e act, logic [`CSR_ADDR_W-1:0] addr,
                                    logic [`CSR_XLEN-1:0] wdata, logic [`CSR_XLEN-1:0] exp_rdata,
                                    logic exp_mie, logic [2:0] mip = 3'b000,
                                    logic [`CSR_CAUSE_W-1:0] cause = '0,
                                    logic [`CSR_XLEN-1:0] pc = '0,
                                    logic [`CSR_XLEN-1:0] tval = '0);
        row_t r;
        r = '{name, act, addr, wdata, exp_rdata, exp_mie, mip, cause, pc, tval};
        rows.push_back(r);
    endfunction

    task automatic check_word(input string name, input csr_word_u exp, input csr_word_u act);
        if (act.raw !== exp.raw) begin
            $display("ERROR %s: expected %h, actual %h", name, exp.raw, act.raw);
            $display("CHECKS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    // One cycle of action, then a read of the same address
    task automatic apply_row(input row_t r);
        @(posedge g_clk);
        #2;
        {mip_meip, mip_mtip, mip_msip} = r.mip;
        csr_addr   = r.addr;
        csr_wdata  = r.wdata;
        trap_cause = r.cause;
        trap_pc    = r.pc;
        trap_mtval = r.tval;
        csr_en     = r.act inside {ACT_WRITE, ACT_SET, ACT_CLEAR, ACT_READ};
        csr_wr     = r.act inside {ACT_WRITE, ACT_SET, ACT_CLEAR};
        csr_wr_set = (r.act == ACT_SET);
        csr_wr_clr = (r.act == ACT_CLEAR);
        trap_cpu   = (r.act == ACT_TRAP_CPU);
        trap_int   = (r.act == ACT_TRAP_INT);
        exec_mret  = (r.act == ACT_MRET);
        @(posedge g_clk);
        #2;
        csr_en     = 1'b1;
        csr_wr     = 1'b0;
        csr_wr_set = 1'b0;
        csr_wr_clr = 1'b0;
        trap_cpu   = 1'b0;
        trap_int   = 1'b0;
        exec_mret  = 1'b0;
        @(negedge g_clk);                        // Mid-cycle, read data settled
        check_word(r.name, r.exp_rdata, csr_rdata);
        check_bit({r.name, " mstatus_mie"}, r.exp_mie, mstatus_mie);
        if (r.addr == `CSR_ADDR_MIE) begin
            check_bit({r.name, " mie_meie"}, r.exp_rdata[11], mie_meie);
            check_bit({r.name, " mie_mtie"}, r.exp_rdata[7], mie_mtie);
            check_bit({r.name, " mie_msie"}, r.exp_rdata[3], mie_msie);
        end
        if (r.addr == `CSR_ADDR_MEPC) begin
            check_word({r.name, " csr_mepc"}, r.exp_rdata, csr_mepc);
        end
        if (r.addr == `CSR_ADDR_MTVEC) begin
            check_word({r.name, " csr_mtvec"}, r.exp_rdata, csr_mtvec);
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        {g_clk, g_resetn, csr_en, csr_wr, csr_wr_set, csr_wr_clr, exec_mret} = '0;
        {mip_meip, mip_mtip, mip_msip, trap_cpu, trap_int} = '0;
        csr_addr   = '0;
        csr_wdata  = '0;
        trap_cause = '0;
        trap_pc    = '0;
        trap_mtval = '0;
        void'($urandom(32'h113b));
        r0 = $urandom();
        r1 = $urandom();
        r2 = $urandom();

        add_row("misa_reset", ACT_READ, `CSR_ADDR_MISA, '0, `CSR_MISA_VALUE, 1'b0);
        add_row("mvendorid", ACT_READ, `CSR_ADDR_MVENDORID, '0, '0, 1'b0);
        add_row("marchid", ACT_READ, `CSR_ADDR_MARCHID, '0, '0, 1'b0);
        add_row("mimpid", ACT_READ, `CSR_ADDR_MIMPID, '0, '0, 1'b0);
        add_row("mhartid", ACT_READ, `CSR_ADDR_MHARTID, '0, '0, 1'b0);
        add_row("medeleg", ACT_READ, `CSR_ADDR_MEDELEG, '0, '0, 1'b0);
        add_row("mideleg", ACT_READ, `CSR_ADDR_MIDELEG, '0, '0, 1'b0);
        add_row("mtvec_reset", ACT_READ, `CSR_ADDR_MTVEC, '0, `CSR_MTVEC_RESET, 1'b0);
        add_row("unknown_addr", ACT_READ, 12'h7C0, '0, '0, 1'b0);
        add_row("scratch_write", ACT_WRITE, `CSR_ADDR_MSCRATCH, r0, r0, 1'b0);
        add_row("scratch_set", ACT_SET, `CSR_ADDR_MSCRATCH, r1, r0 | r1, 1'b0);
        add_row("scratch_clear", ACT_CLEAR, `CSR_ADDR_MSCRATCH, r2, (r0 | r1) & ~r2, 1'b0);
        add_row("mtvec_write", ACT_WRITE, `CSR_ADDR_MTVEC, 32'h1234_5677, 32'h1234_5674, 1'b0);
        add_row("mtvec_set", ACT_SET, `CSR_ADDR_MTVEC, 32'h0000_0F03, 32'h1234_5F74, 1'b0);
        add_row("mtvec_clear", ACT_CLEAR, `CSR_ADDR_MTVEC, 32'h1000_0004, 32'h0234_5F70, 1'b0);
        add_row("mie_write", ACT_WRITE, `CSR_ADDR_MIE, 32'hFFFF_FFFF, 32'h0000_0888, 1'b0);
        add_row("mie_clear", ACT_CLEAR, `CSR_ADDR_MIE, 32'h0000_0080, 32'h0000_0808, 1'b0);
        add_row("mip_read", ACT_READ, `CSR_ADDR_MIP, '0, 32'h0000_0880, 1'b0, 3'b110);
        add_row("mepc_write", ACT_WRITE, `CSR_ADDR_MEPC, 32'h0000_4567, 32'h0000_4566, 1'b0);
        add_row("mstatus_set", ACT_SET, `CSR_ADDR_MSTATUS, 32'h0000_0008, 32'h0000_0008, 1'b1);
        add_row("trap_cpu", ACT_TRAP_CPU, `CSR_ADDR_MSTATUS, '0, 32'h0000_0080, 1'b0,
                3'b000, `CSR_TRAP_IOPCODE, 32'h0000_1235, 32'hDEAD_BEEF);
        add_row("mepc_cpu", ACT_READ, `CSR_ADDR_MEPC, '0, 32'h0000_1234, 1'b0);
        add_row("mcause_cpu", ACT_READ, `CSR_ADDR_MCAUSE, '0, 32'h0000_0002, 1'b0);
        add_row("mtval_cpu", ACT_READ, `CSR_ADDR_MTVAL, '0, 32'hDEAD_BEEF, 1'b0);
        add_row("mret", ACT_MRET, `CSR_ADDR_MSTATUS, '0, 32'h0000_0008, 1'b1);
        add_row("trap_int", ACT_TRAP_INT, `CSR_ADDR_MCAUSE, '0, 32'h8000_0007, 1'b0,
                3'b000, 6'd7, 32'h0000_2000, 32'h1111_1111);
        add_row("mtval_int", ACT_READ, `CSR_ADDR_MTVAL, '0, 32'hDEAD_BEEF, 1'b0);
        add_row("mepc_int", ACT_READ, `CSR_ADDR_MEPC, '0, 32'h0000_2000, 1'b0);
        add_row("mret_again", ACT_MRET, `CSR_ADDR_MSTATUS, '0, 32'h0000_0008, 1'b1);
        add_row("mcause_legal", ACT_WRITE, `CSR_ADDR_MCAUSE, 32'h0000_000B, 32'h0000_000B, 1'b1);
        add_row("mcause_illegal", ACT_WRITE, `CSR_ADDR_MCAUSE, 32'h0000_0009, 32'h0000_000B, 1'b1);
        timeout_limit = rows.size() * 4 + 20;

        repeat (3) @(posedge g_clk);             // Reset held for 3 cycles
        #2;
        g_resetn = 1'b1;

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- csr_file_assertions.sv
// Concurrent checks on the CSR file top level, bound into every
// csr_file instance by the bind statement at the end.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file_assertions (
    input logic                   g_clk,
    input logic                   g_resetn,
    input logic                   csr_en,
    input logic                   csr_wr,
    input logic [`CSR_ADDR_W-1:0] csr_addr,
    input logic                   trap_cpu,
    input logic                   trap_int,
    input logic [`CSR_XLEN-1:0]   csr_mepc,
    input logic [`CSR_XLEN-1:0]   csr_mtvec,
    input logic                   mstatus_mie,
    input logic                   mie_meie,
    input logic                   mie_mtie,
    input logic                   mie_msie
);

    logic mie_write;

    assign mie_write = csr_en && csr_wr && (csr_addr == `CSR_ADDR_MIE);

    mepc_aligned: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_mepc[0] == 1'b0) else $error("mepc bit 0 is set");

    mtvec_direct: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_mtvec[1:0] == 2'b00) else $error("mtvec mode bits are not zero");

    // Any trap leaves interrupts disabled
    trap_clears_mie: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (trap_cpu || trap_int) |=> !mstatus_mie) else $error("MIE still set after trap");

    mie_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !mie_write |=> $stable({mie_meie, mie_mtie, mie_msie}))
        else $error("mie bits changed without a write");

endmodule

bind csr_file csr_file_assertions csr_file_assertions_i (
    .g_clk, .g_resetn, .csr_en, .csr_wr, .csr_addr, .trap_cpu, .trap_int,
    .csr_mepc, .csr_mtvec, .mstatus_mie, .mie_meie, .mie_mtie, .mie_msie
);

//--- csr_file.sv
// Machine-mode CSR file of the RV32 core. Reads are combinational, writes
// and trap/MRET updates land on the next rising edge of g_clk.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file import csr_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    csr_en,
    input  logic                    csr_wr,
    input  logic                    csr_wr_set,
    input  logic                    csr_wr_clr,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  logic [`CSR_XLEN-1:0]    csr_wdata,
    input  logic                    exec_mret,
    input  logic                    mip_meip,
    input  logic                    mip_mtip,
    input  logic                    mip_msip,
    input  logic                    trap_cpu,
    input  logic                    trap_int,
    input  logic [`CSR_CAUSE_W-1:0] trap_cause,
    input  logic [`CSR_XLEN-1:0]    trap_mtval,
    input  logic [`CSR_XLEN-1:0]    trap_pc,
    output logic [`CSR_XLEN-1:0]    csr_rdata,
    output logic [`CSR_XLEN-1:0]    csr_mepc,
    output logic [`CSR_XLEN-1:0]    csr_mtvec,
    output logic                    mstatus_mie,
    output logic                    mie_meie,
    output logic                    mie_mtie,
    output logic                    mie_msie
);

    wire csr_word_u            wdata_u = csr_wdata;
    wire [`CSR_RS_N-1:0]       rd_sel;
    wire                       wen_mstatus;
    wire                       wen_mie;
    wire                       wen_mtvec;
    wire                       wen_mscratch;
    wire                       wen_mepc;
    wire                       wen_mcause;
    wire                       wen_mtval;
    wire                       mstatus_mpie;
    wire [`CSR_XLEN-1:0]       mscratch;
    wire [`CSR_XLEN-1:0]       mcause;
    wire [`CSR_XLEN-1:0]       mtval;

    // --------------------------------------------------
    // Decode, state, read side
    // --------------------------------------------------
    csr_access_decode decode_i (
        .csr_en, .csr_wr, .csr_addr, .csr_wdata(wdata_u), .rd_sel,
        .wen_mstatus, .wen_mie, .wen_mtvec, .wen_mscratch,
        .wen_mepc, .wen_mcause, .wen_mtval
    );

    csr_trap_state trap_state_i (
        .g_clk, .g_resetn, .csr_wr_set, .csr_wr_clr, .csr_wdata(wdata_u),
        .wen_mstatus, .wen_mepc, .wen_mcause, .wen_mtval,
        .exec_mret, .trap_cpu, .trap_int, .trap_cause, .trap_mtval, .trap_pc,
        .mstatus_mie, .mstatus_mpie, .mepc(csr_mepc), .mcause, .mtval
    );

    csr_machine_regs machine_regs_i (
        .g_clk, .g_resetn, .csr_wr_set, .csr_wr_clr, .csr_wdata(wdata_u),
        .wen_mie, .wen_mtvec, .wen_mscratch,
        .mie_meie, .mie_mtie, .mie_msie, .mtvec(csr_mtvec), .mscratch
    );

    csr_read_mux read_mux_i (
        .rd_sel, .mstatus_mie, .mstatus_mpie,
        .mie_meie, .mie_mtie, .mie_msie, .mip_meip, .mip_mtip, .mip_msip,
        .mtvec(csr_mtvec), .mscratch, .mepc(csr_mepc), .mcause, .mtval,
        .csr_rdata
    );

endmodule

//--- csr_read_mux.sv
// Read side of the CSR file. Assembles every readable CSR word and picks
// one with the one-hot select. No select bit set gives zero.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux import csr_pkg::*; (
    input  logic [`CSR_RS_N-1:0] rd_sel,
    input  logic                 mstatus_mie,
    input  logic                 mstatus_mpie,
    input  logic                 mie_meie,
    input  logic                 mie_mtie,
    input  logic                 mie_msie,
    input  logic                 mip_meip,
    input  logic                 mip_mtip,
    input  logic                 mip_msip,
    input  logic [`CSR_XLEN-1:0] mtvec,
    input  logic [`CSR_XLEN-1:0] mscratch,
    input  logic [`CSR_XLEN-1:0] mepc,
    input  logic [`CSR_XLEN-1:0] mcause,
    input  logic [`CSR_XLEN-1:0] mtval,
    output logic [`CSR_XLEN-1:0] csr_rdata
);

    csr_word_u words [`CSR_RS_N];

    // --------------------------------------------------
    // CSR words, indexed like rd_sel
    // --------------------------------------------------
    always_comb begin
        words = '{default: '0};                  // medeleg, mideleg stay zero
        words[`CSR_RS_MSTATUS].status.mie  = mstatus_mie;
        words[`CSR_RS_MSTATUS].status.mpie = mstatus_mpie;
        words[`CSR_RS_MIE].irq.ext         = mie_meie;
        words[`CSR_RS_MIE].irq.tmr         = mie_mtie;
        words[`CSR_RS_MIE].irq.sw          = mie_msie;
        words[`CSR_RS_MIP].irq.ext         = mip_meip;
        words[`CSR_RS_MIP].irq.tmr         = mip_mtip;
        words[`CSR_RS_MIP].irq.sw          = mip_msip;
        words[`CSR_RS_MISA].raw            = `CSR_MISA_VALUE;
        words[`CSR_RS_MVENDORID].raw       = `CSR_MVENDORID;
        words[`CSR_RS_MARCHID].raw         = `CSR_MARCHID;
        words[`CSR_RS_MIMPID].raw          = `CSR_MIMPID;
        words[`CSR_RS_MHARTID].raw         = `CSR_MHARTID;
        words[`CSR_RS_MTVEC].raw           = mtvec;
        words[`CSR_RS_MSCRATCH].raw        = mscratch;
        words[`CSR_RS_MEPC].raw            = mepc;
        words[`CSR_RS_MCAUSE].raw          = mcause;
        words[`CSR_RS_MTVAL].raw           = mtval;
    end

    // AND-OR select
    always_comb begin
        csr_rdata = '0;
        for (int i = 0; i < `CSR_RS_N; i++) begin
            csr_rdata = csr_rdata | ({`CSR_XLEN{rd_sel[i]}} & words[i].raw);
        end
    end

endmodule

//--- csr_machine_regs.sv
// Machine CSRs changed only by software: the mie enable bits, mtvec in
// direct mode and mscratch.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_machine_regs import csr_pkg::*; (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 csr_wr_set,
    input  logic                 csr_wr_clr,
    input  csr_word_u            csr_wdata,
    input  logic                 wen_mie,
    input  logic                 wen_mtvec,
    input  logic                 wen_mscratch,
    output logic                 mie_meie,
    output logic                 mie_mtie,
    output logic                 mie_msie,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mscratch
);

    localparam logic [`CSR_XLEN-1:0] MTVEC_RESET = `CSR_MTVEC_RESET;

    csr_word_u            mie_old;
    csr_word_u            mie_new;
    logic [`CSR_XLEN-1:2] mtvec_base;
    logic [`CSR_XLEN-1:0] mtvec_new;

    always_comb begin
        mie_old = '0;
        mie_old.irq.ext = mie_meie;
        mie_old.irq.tmr = mie_mtie;
        mie_old.irq.sw  = mie_msie;
        mie_new.raw = csr_merge(mie_old.raw, csr_wdata.raw, csr_wr_set, csr_wr_clr);
    end

    assign mtvec     = {mtvec_base, 2'b00};     // Direct mode only
    assign mtvec_new = csr_merge(mtvec, csr_wdata.raw, csr_wr_set, csr_wr_clr);

    // --------------------------------------------------
    // Register updates
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_meie   <= 1'b0;
            mie_mtie   <= 1'b0;
            mie_msie   <= 1'b0;
            mtvec_base <= MTVEC_RESET[`CSR_XLEN-1:2];
            mscratch   <= '0;
        end else begin
            if (wen_mie) begin
                mie_meie <= mie_new.irq.ext;
                mie_mtie <= mie_new.irq.tmr;
                mie_msie <= mie_new.irq.sw;
            end
            if (wen_mtvec) begin
                mtvec_base <= mtvec_new[`CSR_XLEN-1:2];
            end
            if (wen_mscratch) begin
                mscratch <= csr_merge(mscratch, csr_wdata.raw, csr_wr_set, csr_wr_clr);
            end
        end
    end

endmodule

//--- csr_trap_state.sv
// State touched by traps and MRET: mstatus MIE/MPIE, mepc, mcause and
// mtval. Hardware updates take priority over a software write in the
// same cycle.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_state import csr_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    csr_wr_set,
    input  logic                    csr_wr_clr,
    input  csr_word_u               csr_wdata,
    input  logic                    wen_mstatus,
    input  logic                    wen_mepc,
    input  logic                    wen_mcause,
    input  logic                    wen_mtval,
    input  logic                    exec_mret,
    input  logic                    trap_cpu,
    input  logic                    trap_int,
    input  logic [`CSR_CAUSE_W-1:0] trap_cause,
    input  logic [`CSR_XLEN-1:0]    trap_mtval,
    input  logic [`CSR_XLEN-1:0]    trap_pc,
    output logic                    mstatus_mie,
    output logic                    mstatus_mpie,
    output logic [`CSR_XLEN-1:0]    mepc,
    output logic [`CSR_XLEN-1:0]    mcause,
    output logic [`CSR_XLEN-1:0]    mtval
);

    logic                 trap;
    csr_word_u            status_old;
    csr_word_u            status_new;
    logic [`CSR_XLEN-1:0] mepc_new;

    assign trap = trap_cpu || trap_int;

    // Current mstatus laid out as a word so set/clear hit the right bits
    always_comb begin
        status_old = '0;
        status_old.status.mie  = mstatus_mie;
        status_old.status.mpie = mstatus_mpie;
        status_new.raw = csr_merge(status_old.raw, csr_wdata.raw, csr_wr_set, csr_wr_clr);
    end

    assign mepc_new = csr_merge(mepc, csr_wdata.raw, csr_wr_set, csr_wr_clr);

    // --------------------------------------------------
    // mstatus
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
        end else if (trap) begin
            mstatus_mpie <= mstatus_mie;         // Stack the enable
            mstatus_mie  <= 1'b0;
        end else if (exec_mret) begin
            mstatus_mie  <= mstatus_mpie;        // Unstack on return
            mstatus_mpie <= 1'b0;
        end else if (wen_mstatus) begin
            mstatus_mie  <= status_new.status.mie;
            mstatus_mpie <= status_new.status.mpie;
        end
    end

    // --------------------------------------------------
    // mepc, mcause, mtval
    // --------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc <= '0;
        end else if (trap) begin
            mepc <= {trap_pc[`CSR_XLEN-1:1], 1'b0};
        end else if (wen_mepc) begin
            mepc <= {mepc_new[`CSR_XLEN-1:1], 1'b0}; // IALIGN=16, bit 0 stays low
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcause <= '0;
        end else if (trap) begin
            mcause <= {trap_int, {(`CSR_XLEN-`CSR_CAUSE_W-1){1'b0}}, trap_cause};
        end else if (wen_mcause) begin
            mcause <= csr_merge(mcause, csr_wdata.raw, csr_wr_set, csr_wr_clr);
        end
    end

    // Interrupts carry no trap value
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtval <= '0;
        end else if (trap_cpu) begin
            mtval <= trap_mtval;
        end else if (wen_mtval) begin
            mtval <= csr_merge(mtval, csr_wdata.raw, csr_wr_set, csr_wr_clr);
        end
    end

endmodule

//--- csr_access_decode.sv
// Address decode for the CSR file. Turns the access address into a one-hot
// read select and per-register write strobes. mcause writes carrying an
// unsupported exception code are dropped here.

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_access_decode import csr_pkg::*; (
    input  logic                    csr_en,
    input  logic                    csr_wr,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  csr_word_u               csr_wdata,
    output logic [`CSR_RS_N-1:0]    rd_sel,
    output logic                    wen_mstatus,
    output logic                    wen_mie,
    output logic                    wen_mtvec,
    output logic                    wen_mscratch,
    output logic                    wen_mepc,
    output logic                    wen_mcause,
    output logic                    wen_mtval
);

    logic cause_ok;

    // --------------------------------------------------
    // Read select, one bit per known CSR
    // --------------------------------------------------
    assign rd_sel[`CSR_RS_MSTATUS]   = csr_en && (csr_addr == `CSR_ADDR_MSTATUS);
    assign rd_sel[`CSR_RS_MISA]      = csr_en && (csr_addr == `CSR_ADDR_MISA);
    assign rd_sel[`CSR_RS_MEDELEG]   = csr_en && (csr_addr == `CSR_ADDR_MEDELEG);
    assign rd_sel[`CSR_RS_MIDELEG]   = csr_en && (csr_addr == `CSR_ADDR_MIDELEG);
    assign rd_sel[`CSR_RS_MIE]       = csr_en && (csr_addr == `CSR_ADDR_MIE);
    assign rd_sel[`CSR_RS_MTVEC]     = csr_en && (csr_addr == `CSR_ADDR_MTVEC);
    assign rd_sel[`CSR_RS_MSCRATCH]  = csr_en && (csr_addr == `CSR_ADDR_MSCRATCH);
    assign rd_sel[`CSR_RS_MEPC]      = csr_en && (csr_addr == `CSR_ADDR_MEPC);
    assign rd_sel[`CSR_RS_MCAUSE]    = csr_en && (csr_addr == `CSR_ADDR_MCAUSE);
    assign rd_sel[`CSR_RS_MTVAL]     = csr_en && (csr_addr == `CSR_ADDR_MTVAL);
    assign rd_sel[`CSR_RS_MIP]       = csr_en && (csr_addr == `CSR_ADDR_MIP);
    assign rd_sel[`CSR_RS_MVENDORID] = csr_en && (csr_addr == `CSR_ADDR_MVENDORID);
    assign rd_sel[`CSR_RS_MARCHID]   = csr_en && (csr_addr == `CSR_ADDR_MARCHID);
    assign rd_sel[`CSR_RS_MIMPID]    = csr_en && (csr_addr == `CSR_ADDR_MIMPID);
    assign rd_sel[`CSR_RS_MHARTID]   = csr_en && (csr_addr == `CSR_ADDR_MHARTID);

    // Only synchronous exception codes this core raises
    assign cause_ok = (csr_wdata.raw[`CSR_XLEN-1:`CSR_CAUSE_W] == '0) &&
                      (csr_wdata.raw[`CSR_CAUSE_W-1:0] inside {
                          `CSR_TRAP_IALIGN,  `CSR_TRAP_IACCESS,
                          `CSR_TRAP_IOPCODE, `CSR_TRAP_BREAKPT,
                          `CSR_TRAP_LDALIGN, `CSR_TRAP_LDACCESS,
                          `CSR_TRAP_STALIGN, `CSR_TRAP_STACCESS,
                          `CSR_TRAP_ECALLM});

    // --------------------------------------------------
    // Write strobes, rd_sel already carries csr_en
    // --------------------------------------------------
    assign wen_mstatus  = csr_wr && rd_sel[`CSR_RS_MSTATUS];
    assign wen_mie      = csr_wr && rd_sel[`CSR_RS_MIE];
    assign wen_mtvec    = csr_wr && rd_sel[`CSR_RS_MTVEC];
    assign wen_mscratch = csr_wr && rd_sel[`CSR_RS_MSCRATCH];
    assign wen_mepc     = csr_wr && rd_sel[`CSR_RS_MEPC];
    assign wen_mcause   = csr_wr && rd_sel[`CSR_RS_MCAUSE] && cause_ok;
    assign wen_mtval    = csr_wr && rd_sel[`CSR_RS_MTVAL];

endmodule

//--- csr_pkg.sv
// Types and helpers shared by the CSR file blocks. The word union gives
// the mstatus and mie/mip layouts over one 32-bit CSR word.

`include "csr_settings.svh"

package csr_pkg;

    typedef union packed {
        logic [`CSR_XLEN-1:0] raw;
        struct packed {
            logic [`CSR_XLEN-1:8] hi;   // SD, MPP, FS and friends, all zero
            logic                 mpie;
            logic [6:4]           mid;
            logic                 mie;
            logic [2:0]           lo;
        } status;
        struct packed {
            logic [`CSR_XLEN-1:12] hi;
            logic                  ext; // MEIE / MEIP
            logic [10:8]           res2;
            logic                  tmr; // MTIE / MTIP
            logic [6:4]            res1;
            logic                  sw;  // MSIE / MSIP
            logic [2:0]            res0;
        } irq;
    } csr_word_u;

    // New field value for a write, a set or a clear
    function automatic logic [`CSR_XLEN-1:0] csr_merge(
        input logic [`CSR_XLEN-1:0] old_val,
        input logic [`CSR_XLEN-1:0] wdata,
        input logic                 set,
        input logic                 clr
    );
        if (set) begin
            return old_val | wdata;
        end else if (clr) begin
            return old_val & ~wdata;
        end
        return wdata;
    endfunction

endpackage

//--- csr_settings.svh
// Widths, CSR addresses, constant register values and exception codes
// for the machine-mode CSR file. Included by the package, the RTL and
// the testbench.

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN            32
`define CSR_ADDR_W          12
`define CSR_CAUSE_W         6

// --------------------------------------------------
// CSR addresses
// --------------------------------------------------
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MEDELEG    12'h302
`define CSR_ADDR_MIDELEG    12'h303
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14

// Bit positions in the one-hot read select
`define CSR_RS_MSTATUS      0
`define CSR_RS_MISA         1
`define CSR_RS_MEDELEG      2
`define CSR_RS_MIDELEG      3
`define CSR_RS_MIE          4
`define CSR_RS_MTVEC        5
`define CSR_RS_MSCRATCH     6
`define CSR_RS_MEPC         7
`define CSR_RS_MCAUSE       8
`define CSR_RS_MTVAL        9
`define CSR_RS_MIP          10
`define CSR_RS_MVENDORID    11
`define CSR_RS_MARCHID      12
`define CSR_RS_MIMPID       13
`define CSR_RS_MHARTID      14
`define CSR_RS_N            15

// --------------------------------------------------
// Reset and constant register values
// --------------------------------------------------
`define CSR_MTVEC_RESET     32'hC000_0000
`define CSR_MISA_VALUE      32'h4080_1106 // MXL=1, X M I C B
`define CSR_MVENDORID       32'h0000_0000
`define CSR_MARCHID         32'h0000_0000
`define CSR_MIMPID          32'h0000_0000
`define CSR_MHARTID         32'h0000_0000

// Exception codes accepted by mcause
`define CSR_TRAP_IALIGN     6'd0
`define CSR_TRAP_IACCESS    6'd1
`define CSR_TRAP_IOPCODE    6'd2
`define CSR_TRAP_BREAKPT    6'd3
`define CSR_TRAP_LDALIGN    6'd4
`define CSR_TRAP_LDACCESS   6'd5
`define CSR_TRAP_STALIGN    6'd6
`define CSR_TRAP_STACCESS   6'd7
`define CSR_TRAP_ECALLM     6'd11

`endif
